/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0 -Wno-fatal
TOP      = snd_tb
FILELIST = vlog.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

/* bench/snd_tb.sv */
/* testbench for snd_top, ROM model answers with a random 0-3 cycle extra ok delay
   expected audio is a nibble replay of the ROM contents, cen_mix every clk, cen_oki every 8
   phrases 126 and 127 are overwritten with full scale deltas for the clamp tests */
`timescale 1ns/1ps
`default_nettype none

module snd_tb
    import snd_pkg::*;
();

    localparam int TIMEOUT  = 20000;    // ~4 phrases of ~300 clk plus bus tests, wide margin
    localparam int NIB      = 2 * PHRASE_LEN;
    localparam int ROM_SIZE = 1 << ROM_AW;
    localparam logic [15:0] UNMAPPED [0:6] = '{16'h8800, 16'h9000, 16'h97ff, 16'h9801,
                                               16'ha001, 16'hc000, 16'hffff};

    logic        clk = 1'b0;
    logic        rst_n;
    logic [15:0] cpu_addr;
    logic [ 7:0] cpu_dout;
    logic        cpu_mreq_n, cpu_wr_n;
    logic [ 7:0] cpu_din;
    logic        cpu_wait_n, cpu_nmi_n;
    logic        snd_irq;
    logic [ 7:0] snd_latch;
    logic [ROM_AW-1:0] rom_addr;
    logic        rom_cs, rom_ok;
    logic [ 7:0] rom_data;
    logic        cen_oki, cen_mix;
    logic signed [15:0] fm_snd, sound;
    logic        sample, peak;

    logic [7:0]  rom [0:ROM_SIZE-1];
    logic [7:0]  ram_ref [0:2**RAM_AW-1];    // shadow of the work RAM
    int unsigned req_dly;
    logic [ROM_AW-1:0] req_addr;
    logic        req_act;
    logic [2:0]  oki_cnt;
    int          cycles = 0;
    int          errors = 0;
    int          checks = 0;
    logic        chk_on = 1'b0;    // comparator armed
    int          chk_phrase = 0;
    int          chk_idx = 0;      // nibbles matched so far

    snd_top DUT(
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .cpu_addr   ( cpu_addr   ),
        .cpu_dout   ( cpu_dout   ),
        .cpu_mreq_n ( cpu_mreq_n ),
        .cpu_wr_n   ( cpu_wr_n   ),
        .cpu_din    ( cpu_din    ),
        .cpu_wait_n ( cpu_wait_n ),
        .cpu_nmi_n  ( cpu_nmi_n  ),
        .snd_irq    ( snd_irq    ),
        .snd_latch  ( snd_latch  ),
        .rom_addr   ( rom_addr   ),
        .rom_cs     ( rom_cs     ),
        .rom_data   ( rom_data   ),
        .rom_ok     ( rom_ok     ),
        .cen_oki    ( cen_oki    ),
        .cen_mix    ( cen_mix    ),
        .fm_snd     ( fm_snd     ),
        .sound      ( sound      ),
        .sample     ( sample     ),
        .peak       ( peak       )
    );

    always #10 clk = ~clk;    // 20 ns

    always @(posedge clk) begin
        if (!rst_n) begin
            oki_cnt <= '0;
            cen_oki <= 1'b0;
            cen_mix <= 1'b0;
        end else begin
            oki_cnt <= oki_cnt + 1'b1;
            cen_oki <= (oki_cnt == 3'd7);
            cen_mix <= 1'b1;    // mixer runs every clk
        end
    end

    // ROM model, one cycle ok pulse once the address has been held long enough
    always @(posedge clk) begin
        if (rom_ok) begin
            rom_ok <= 1'b0;
        end else if (!rom_cs) begin
            req_act <= 1'b0;
        end else if (!req_act || rom_addr != req_addr) begin    // new or moved request
            req_act  <= 1'b1;
            req_addr <= rom_addr;
            req_dly  <= $urandom % 4;
        end else if (req_dly == 0) begin
            rom_ok   <= 1'b1;
            rom_data <= rom[rom_addr];
            req_act  <= 1'b0;
        end else begin
            req_dly <= req_dly - 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic int phrase_addr(input int ph, input int idx);
        return int'(ADPCM_BASE) + (ph << PHRASE_SHIFT) + idx;
    endfunction

    // accumulator after k nibbles of a phrase, delta x16 with saturation
    function automatic int ref_pcm(input int ph, input int k);
        int acc;
        int nib;
        int lim;
        int i;
        logic [7:0] b;
        acc = 0;
        lim = 1 << (SAMPLE_W - 1);
        for (i = 0; i < k; i++) begin
            b   = rom[phrase_addr(ph, i / 2)];
            nib = (i % 2 == 0) ? b[7:4] : b[3:0];    // high nibble first
            if (nib > 7) nib -= 16;
            acc += nib * 16;
            if (acc > lim - 1) acc = lim - 1;
            if (acc < -lim) acc = -lim;
        end
        return acc;
    endfunction

    function automatic int mix_sum(input int fm, input int pcm);
        int fg;
        int pg;
        fg = int'(FM_GAIN);
        pg = int'(PCM_GAIN);
        return ((fm * fg) >>> 4) + ((pcm * pg) >>> 4);
    endfunction

    function automatic int clamp16(input int v);
        if (v > 32767) return 32767;
        if (v < -32768) return -32768;
        return v;
    endfunction

    task automatic expect_eq(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("** Error at %0t: %s got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge clk);
        cpu_addr   <= addr;
        cpu_dout   <= data;
        cpu_mreq_n <= 1'b0;
        cpu_wr_n   <= 1'b0;
        @(posedge clk);
        cpu_mreq_n <= 1'b1;
        cpu_wr_n   <= 1'b1;
    endtask

    task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
        @(posedge clk);
        cpu_addr   <= addr;
        cpu_mreq_n <= 1'b0;
        cpu_wr_n   <= 1'b1;
        do @(posedge clk); while (!cpu_wait_n);    // ROM wait states
        data = cpu_din;
        cpu_mreq_n <= 1'b1;
    endtask

    task automatic rom_reads(input int n);
        int a;
        logic [7:0] got;
        repeat (n) begin
            a = $urandom % (1 << CPU_ROM_AW);
            cpu_read(16'(a), got);
            expect_eq($sformatf("ROM byte at %04h", a), got, rom[a]);
        end
    endtask

    task automatic start_phrase(input int ph);
        adpcm_cmd_u cmd;
        cmd.play.start  = 1'b1;
        cmd.play.phrase = 7'(ph);
        cpu_write(PCM_ADDR, cmd);
        chk_phrase = ph;
        @(posedge clk);    // old sample leaves the mixer
        chk_idx <= 0;
        chk_on  <= 1'b1;
    endtask

    task automatic play_phrase(input int ph, input int n_reads);
        logic [7:0] st;
        start_phrase(ph);
        cpu_read(PCM_ADDR, st);
        expect_eq("status while playing", st, 1);
        rom_reads(n_reads);    // compete with the phrase fetch
        do cpu_read(PCM_ADDR, st); while (st[0]);
        expect_eq("status after phrase", st, 0);
        repeat (3) @(posedge clk);
        expect_eq("nibbles played", chk_idx, NIB);
        chk_on <= 1'b0;
    endtask

    task automatic check_out(input int exp_sound, input logic exp_peak, input string what);
        do @(posedge clk); while (!sample);
        expect_eq({what, " sound"}, sound, exp_sound);
        expect_eq({what, " peak"}, peak, exp_peak);
    endtask

    // new fm level against the held ADPCM sample of a finished phrase
    task automatic check_mix(input int fm, input int ph, input string what);
        int raw;
        raw = mix_sum(fm, ref_pcm(ph, NIB));
        @(posedge clk);
        fm_snd <= 16'(fm);
        @(posedge clk);
        check_out(clamp16(raw), raw != clamp16(raw), what);
    endtask

    // phrase comparison, the DUT may hold a value or move one nibble on
    always @(posedge clk) begin : compare_out
        int exp_now;
        int exp_next;
        if (chk_on && sample) begin
            exp_now  = mix_sum(0, ref_pcm(chk_phrase, chk_idx));
            exp_next = (chk_idx < NIB) ? mix_sum(0, ref_pcm(chk_phrase, chk_idx + 1)) : exp_now;
            checks++;
            if (chk_idx < NIB && sound == exp_next) begin
                chk_idx <= chk_idx + 1;
            end else if (sound != exp_now) begin
                errors++;
                $display("** Error at %0t: phrase %0d nibble %0d sound %0d, expected %0d",
                         $time, chk_phrase, chk_idx, sound, exp_now);
            end
            if (peak) begin
                errors++;
                $display("** Error at %0t: peak set on an in-range sample", $time);
            end
        end
    end

    initial begin : main
        int i;
        int a;
        int ph;
        logic [7:0] d;
        logic [7:0] got;
        int ram_addrs[$];
        adpcm_cmd_u stop_cmd;

        void'($urandom(32'hf9eb4ba6));
        for (i = 0; i < ROM_SIZE; i++) rom[i] = 8'($urandom);
        for (i = 0; i < PHRASE_LEN; i++) begin
            rom[phrase_addr(127, i)] = 8'h77;    // +7 every nibble
            rom[phrase_addr(126, i)] = 8'h88;    // -8 every nibble
        end

        rst_n      = 1'b0;
        cpu_addr   = '0;
        cpu_dout   = '0;
        cpu_mreq_n = 1'b1;
        cpu_wr_n   = 1'b1;
        snd_irq    = 1'b0;
        snd_latch  = '0;
        rom_data   = '0;
        rom_ok     = 1'b0;
        req_act    = 1'b0;
        req_addr   = '0;
        req_dly    = 0;
        oki_cnt    = '0;
        cen_oki    = 1'b0;
        cen_mix    = 1'b0;
        fm_snd     = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // work RAM and open bus
        for (i = 0; i < 24; i++) begin
            a = $urandom % (1 << RAM_AW);
            d = 8'($urandom);
            ram_ref[a] = d;    // repeats keep the last byte
            ram_addrs.push_back(a);
            cpu_write(RAM_BASE + 16'(a), d);
        end
        foreach (ram_addrs[j]) begin
            cpu_read(RAM_BASE + 16'(ram_addrs[j]), got);
            expect_eq($sformatf("RAM byte at %04h", RAM_BASE + 16'(ram_addrs[j])),
                      got, ram_ref[ram_addrs[j]]);
        end
        foreach (UNMAPPED[j]) begin
            cpu_read(UNMAPPED[j], got);
            expect_eq($sformatf("open bus at %04h", UNMAPPED[j]), got, 8'hff);
        end
        cpu_read(PCM_ADDR, got);
        expect_eq("status after reset", got, 0);

        // NMI from the main CPU, cleared by the latch read
        expect_eq("nmi_n after reset", cpu_nmi_n, 1);
        d = 8'($urandom);
        @(posedge clk);
        snd_latch <= d;
        snd_irq   <= 1'b1;
        @(posedge clk);    // flip-flop sets here
        @(posedge clk);
        expect_eq("nmi_n after snd_irq rise", cpu_nmi_n, 0);
        snd_irq <= 1'b0;
        cpu_read(LATCH_ADDR, got);
        expect_eq("latch read", got, d);
        @(posedge clk);
        expect_eq("nmi_n after latch read", cpu_nmi_n, 1);

        rom_reads(8);    // idle port

        ph = $urandom % 126;
        play_phrase(ph, 6);

        // stop in the middle of a phrase
        ph = $urandom % 126;
        start_phrase(ph);
        while (chk_idx < 8) @(posedge clk);
        chk_on <= 1'b0;
        stop_cmd = '0;
        stop_cmd.ctrl.stop = 1'b1;
        cpu_write(PCM_ADDR, stop_cmd);
        cpu_read(PCM_ADDR, got);
        expect_eq("status after stop", got, 0);
        check_out(0, 1'b0, "output after stop");

        // saturation at both ends, full scale ADPCM held after the phrase
        play_phrase(127, 0);
        check_mix(32767, 127, "fm max with pcm max");
        check_mix(1000, 127, "in-range mix");
        check_mix(0, 127, "pcm only");
        play_phrase(126, 0);
        check_mix(-32768, 126, "fm min with pcm min");
        check_mix(-20000, 126, "negative in-range mix");
        check_mix(0, 126, "pcm only");

        repeat (4) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/snd_adpcm.sv */
/* single voice ADPCM player, simplified: each nibble is a signed delta times 16
   one nibble per cen_oki pulse, high nibble first; the nibble timer stalls on ROM waits
   a command written while a fetch is pending retargets that fetch */
`timescale 1ns/1ps
`default_nettype none

module snd_adpcm
    import snd_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       cen_oki,
    input  wire                       pcm_we,
    input  wire  [7:0]                cpu_dout,
    input  wire  [7:0]                pcm_rom_data,
    input  wire                       pcm_rom_ok,
    output logic                      pcm_rom_cs,
    output logic [ROM_AW-1:0]         pcm_rom_addr,
    output logic [7:0]                pcm_status,
    output logic signed [SAMPLE_W-1:0] pcm_snd
);

    adpcm_cmd_u cmd;
    logic we_l, cmd_wr;
    logic busy;
    logic [6:0] phrase_q;
    logic [BYTE_CW-1:0] byte_cnt;
    logic [7:0] byte_q;                 // current ROM byte
    logic byte_vld, nib_hi;
    logic step;
    logic signed [3:0] nib;
    logic signed [SAMPLE_W:0] acc_sum;  // one guard bit
    logic signed [SAMPLE_W-1:0] acc, acc_nx;

    assign cmd    = cpu_dout;
    assign cmd_wr = pcm_we & ~we_l;             // once per bus write
    assign step   = cen_oki & busy & byte_vld;  // no step while the byte is missing

    assign nib     = nib_hi ? byte_q[7:4] : byte_q[3:0];
    assign acc_sum = acc + (nib <<< 4);

    // clamp to the signed sample range
    always_comb begin
        if (acc_sum[SAMPLE_W] != acc_sum[SAMPLE_W-1])
            acc_nx = acc_sum[SAMPLE_W] ? {1'b1, {(SAMPLE_W-1){1'b0}}}
                                       : {1'b0, {(SAMPLE_W-1){1'b1}}};
        else
            acc_nx = acc_sum[SAMPLE_W-1:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_l       <= 1'b0;
            busy       <= 1'b0;
            pcm_rom_cs <= 1'b0;
            byte_vld   <= 1'b0;
            nib_hi     <= 1'b0;
            byte_cnt   <= '0;
            phrase_q   <= '0;
            acc        <= '0;
        end else begin
            we_l <= pcm_we;
            if (pcm_rom_cs && pcm_rom_ok) begin   // byte arrived
                pcm_rom_cs <= 1'b0;
                byte_vld   <= 1'b1;
                nib_hi     <= 1'b1;
            end
            if (cmd_wr && cmd.play.start) begin
                busy       <= 1'b1;
                phrase_q   <= cmd.play.phrase;
                byte_cnt   <= '0;
                acc        <= '0;
                byte_vld   <= 1'b0;
                pcm_rom_cs <= 1'b1;               // first byte right away
            end else if (cmd_wr && cmd.ctrl.stop) begin
                busy <= 1'b0;
                acc  <= '0;                       // silence
            end else if (step) begin
                acc    <= acc_nx;
                nib_hi <= 1'b0;
                if (!nib_hi) begin                // low nibble done, byte used up
                    byte_vld <= 1'b0;
                    if (byte_cnt == BYTE_CW'(PHRASE_LEN-1)) begin
                        busy <= 1'b0;
                    end else begin
                        byte_cnt   <= byte_cnt + 1'b1;
                        pcm_rom_cs <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pcm_rom_cs && pcm_rom_ok) byte_q <= pcm_rom_data;
    end

    assign pcm_rom_addr = ADPCM_BASE + (ROM_AW'(phrase_q) << PHRASE_SHIFT) + ROM_AW'(byte_cnt);
    assign pcm_status   = {7'd0, busy};
    assign pcm_snd      = acc;

    a_in_phrase: assert property (@(posedge clk) disable iff (!rst_n)
        pcm_rom_cs |-> pcm_rom_addr >= ADPCM_BASE
                       && pcm_rom_addr[PHRASE_SHIFT-1:0] < PHRASE_LEN)
        else $error("ADPCM fetch outside its phrase");

endmodule

`default_nettype wire

/* design/snd_decode.sv */
/* sound CPU address decoder, work RAM and NMI flip-flop
   chip selects and read data are combinational, valid only while cpu_mreq_n is low
   RAM and latch accesses never wait; ROM reads wait for cpu_rom_ok */
`timescale 1ns/1ps
`default_nettype none

module snd_decode
    import snd_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [15:0] cpu_addr,
    input  wire  [ 7:0] cpu_dout,
    input  wire         cpu_mreq_n,
    input  wire         cpu_wr_n,
    input  wire         snd_irq,
    input  wire  [ 7:0] snd_latch,
    input  wire  [ 7:0] cpu_rom_data,
    input  wire         cpu_rom_ok,
    input  wire  [ 7:0] pcm_status,
    output logic [ 7:0] cpu_din,
    output logic        cpu_wait_n,
    output logic        cpu_nmi_n,
    output logic        cpu_rom_cs,
    output logic [14:0] cpu_rom_addr,
    output logic        pcm_we
);

    logic rom_cs, ram_cs, pcm_cs, latch_cs;
    logic [7:0] ram [0:2**RAM_AW-1];
    logic [7:0] ram_dout;
    logic irq_l;    // last snd_irq, for edge detect
    logic nmi_q;

    always_comb begin
        rom_cs   = 1'b0;
        ram_cs   = 1'b0;
        pcm_cs   = 1'b0;
        latch_cs = 1'b0;
        if (!cpu_mreq_n) begin
            if (cpu_addr[15:CPU_ROM_AW] == '0) rom_cs = 1'b1;                       // 0000-7fff
            else if (cpu_addr[15:RAM_AW] == RAM_BASE[15:RAM_AW]) ram_cs = 1'b1;     // 8000-87ff
            else if (cpu_addr == PCM_ADDR) pcm_cs = 1'b1;
            else if (cpu_addr == LATCH_ADDR) latch_cs = 1'b1;
        end
    end

    assign cpu_rom_cs   = rom_cs;
    assign cpu_rom_addr = cpu_addr[CPU_ROM_AW-1:0];
    assign pcm_we       = pcm_cs & ~cpu_wr_n;
    assign cpu_wait_n   = ~(rom_cs & ~cpu_rom_ok);    // stretch until ROM data arrives

    // work RAM, asynchronous read
    always_ff @(posedge clk) begin
        if (ram_cs && !cpu_wr_n) ram[cpu_addr[RAM_AW-1:0]] <= cpu_dout;
    end
    assign ram_dout = ram[cpu_addr[RAM_AW-1:0]];

    always_comb begin
        if (rom_cs)        cpu_din = cpu_rom_data;
        else if (ram_cs)   cpu_din = ram_dout;
        else if (latch_cs) cpu_din = snd_latch;
        else if (pcm_cs)   cpu_din = pcm_status;
        else               cpu_din = 8'hff;       // open bus
    end

    // edge triggered NMI, latch access acknowledges it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_l <= 1'b0;
            nmi_q <= 1'b0;
        end else begin
            irq_l <= snd_irq;
            if (latch_cs) nmi_q <= 1'b0;              // clear wins over a new edge
            else if (snd_irq && !irq_l) nmi_q <= 1'b1;
        end
    end
    assign cpu_nmi_n = ~(nmi_q & ~latch_cs);     // released within the latch cycle

    a_one_cs: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({rom_cs, ram_cs, pcm_cs, latch_cs}))
        else $error("more than one chip select active");

endmodule

`default_nettype wire

/* design/snd_mixer.sv */
/* two channel mixer, fixed 4.4 gains from the package
   output updates one clk after cen_mix; peak flags a clamped sample */
`timescale 1ns/1ps
`default_nettype none

module snd_mixer
    import snd_pkg::*;
(
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        cen_mix,
    input  wire  signed [15:0]         fm_snd,
    input  wire  signed [SAMPLE_W-1:0] pcm_snd,
    output logic signed [15:0]         sound,
    output logic                       sample,
    output logic                       peak
);

    logic signed [24:0] fm_prod;     // 16 x 9 bits
    logic signed [20:0] pcm_prod;    // 12 x 9 bits
    logic signed [25:0] mix_sum;

    // gains are unsigned, extend with a zero before the signed multiply
    assign fm_prod  = fm_snd * $signed({1'b0, FM_GAIN});
    assign pcm_prod = pcm_snd * $signed({1'b0, PCM_GAIN});
    assign mix_sum  = (fm_prod >>> 4) + (pcm_prod >>> 4);    // drop the fraction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sound  <= '0;
            sample <= 1'b0;
            peak   <= 1'b0;
        end else begin
            sample <= cen_mix;    // marks the cycle with a fresh output
            if (cen_mix) begin
                if (mix_sum > 26'sd32767) begin
                    sound <= 16'sh7fff;
                    peak  <= 1'b1;
                end else if (mix_sum < -26'sd32768) begin
                    sound <= 16'sh8000;
                    peak  <= 1'b1;
                end else begin
                    sound <= mix_sum[15:0];
                    peak  <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/snd_pkg.sv */
/* shared constants for the sound board: CPU address map, ROM layout and mixer gains
   ADPCM data lives above the CPU program in the one 18-bit ROM */
`default_nettype none

package snd_pkg;

    // CPU address map
    localparam int          CPU_ROM_AW = 15;          // 0000-7fff program window
    localparam int          RAM_AW     = 11;          // 2 KiB work RAM
    localparam logic [15:0] RAM_BASE   = 16'h8000;    // 8000-87ff
    localparam logic [15:0] PCM_ADDR   = 16'h9800;    // ADPCM command / status
    localparam logic [15:0] LATCH_ADDR = 16'ha000;    // main CPU latch

    // shared ROM layout
    localparam int              ROM_AW       = 18;
    localparam logic [ROM_AW-1:0] ADPCM_BASE = 18'h08000;
    localparam int              PHRASE_SHIFT = 8;     // 256 byte slot per phrase
    localparam int              PHRASE_LEN   = 16;    // bytes actually played
    localparam int              BYTE_CW      = $clog2(PHRASE_LEN);

    // mixer, gains are 4.4 fixed point
    localparam logic [7:0] FM_GAIN  = 8'h10;          // x1
    localparam logic [7:0] PCM_GAIN = 8'h20;          // x2
    localparam int         SAMPLE_W = 12;             // ADPCM output, signed

    // one CPU write to the player, two readings
    typedef struct packed {
        logic       start;      // set for play
        logic [6:0] phrase;
    } adpcm_play_t;

    typedef struct packed {
        logic       start;      // clear for control
        logic [5:0] unused;
        logic       stop;
    } adpcm_ctrl_t;

    typedef union packed {
        adpcm_play_t play;
        adpcm_ctrl_t ctrl;
    } adpcm_cmd_u;

endpackage

`default_nettype wire

/* design/snd_rom_arb.sv */
/* shares the single ROM port between CPU fetch and ADPCM fetch
   CPU wins when the port is idle; the owner keeps it until its cs drops
   a requester that is not granted just sees its ok low */
`timescale 1ns/1ps
`default_nettype none

module snd_rom_arb
    import snd_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire               cpu_rom_cs,
    input  wire  [14:0]       cpu_rom_addr,
    input  wire               pcm_rom_cs,
    input  wire  [ROM_AW-1:0] pcm_rom_addr,
    input  wire  [ 7:0]       rom_data,
    input  wire               rom_ok,
    output logic [ 7:0]       cpu_rom_data,
    output logic              cpu_rom_ok,
    output logic [ 7:0]       pcm_rom_data,
    output logic              pcm_rom_ok,
    output logic [ROM_AW-1:0] rom_addr,
    output logic              rom_cs
);

    logic gnt_cpu, gnt_pcm;    // both low = idle
    logic free;

    // port is free when idle or when the owner has dropped its request
    assign free = (~gnt_cpu | ~cpu_rom_cs) & (~gnt_pcm | ~pcm_rom_cs);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gnt_cpu <= 1'b0;
            gnt_pcm <= 1'b0;
        end else if (free) begin
            gnt_cpu <= cpu_rom_cs;                  // fixed priority
            gnt_pcm <= ~cpu_rom_cs & pcm_rom_cs;
        end
    end

    assign rom_cs   = (gnt_cpu & cpu_rom_cs) | (gnt_pcm & pcm_rom_cs);
    assign rom_addr = gnt_pcm ? pcm_rom_addr : ROM_AW'(cpu_rom_addr);  // CPU window at 0

    assign cpu_rom_ok   = gnt_cpu & cpu_rom_cs & rom_ok;
    assign pcm_rom_ok   = gnt_pcm & pcm_rom_cs & rom_ok;
    assign cpu_rom_data = rom_data;   // only meaningful with its ok
    assign pcm_rom_data = rom_data;

    // a pending access must finish on the same owner
    a_gnt_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rom_cs && !rom_ok |=> $stable({gnt_cpu, gnt_pcm}))
        else $error("ROM grant moved during a pending access");

endmodule

`default_nettype wire

/* design/snd_top.sv */
/* sound board top: external CPU bus, one shared ROM port, external FM input
   the ROM port must hold rom_ok tied to the presented address */
`timescale 1ns/1ps
`default_nettype none

module snd_top
    import snd_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    // sound CPU bus
    input  wire  [15:0]       cpu_addr,
    input  wire  [ 7:0]       cpu_dout,
    input  wire               cpu_mreq_n,
    input  wire               cpu_wr_n,
    output logic [ 7:0]       cpu_din,
    output logic              cpu_wait_n,
    output logic              cpu_nmi_n,
    // main CPU
    input  wire               snd_irq,
    input  wire  [ 7:0]       snd_latch,
    // shared ROM
    output logic [ROM_AW-1:0] rom_addr,
    output logic              rom_cs,
    input  wire  [ 7:0]       rom_data,
    input  wire               rom_ok,
    // audio
    input  wire               cen_oki,
    input  wire               cen_mix,
    input  wire  signed [15:0] fm_snd,
    output logic signed [15:0] sound,
    output logic              sample,
    output logic              peak
);

    logic        cpu_rom_cs, cpu_rom_ok;
    logic [14:0] cpu_rom_addr;
    logic [ 7:0] cpu_rom_data;
    logic        pcm_rom_cs, pcm_rom_ok;
    logic [ROM_AW-1:0] pcm_rom_addr;
    logic [ 7:0] pcm_rom_data;
    logic        pcm_we;
    logic [ 7:0] pcm_status;
    logic signed [SAMPLE_W-1:0] pcm_snd;

    snd_decode u_decode(
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .cpu_addr     ( cpu_addr     ),
        .cpu_dout     ( cpu_dout     ),
        .cpu_mreq_n   ( cpu_mreq_n   ),
        .cpu_wr_n     ( cpu_wr_n     ),
        .snd_irq      ( snd_irq      ),
        .snd_latch    ( snd_latch    ),
        .cpu_rom_data ( cpu_rom_data ),
        .cpu_rom_ok   ( cpu_rom_ok   ),
        .pcm_status   ( pcm_status   ),
        .cpu_din      ( cpu_din      ),
        .cpu_wait_n   ( cpu_wait_n   ),
        .cpu_nmi_n    ( cpu_nmi_n    ),
        .cpu_rom_cs   ( cpu_rom_cs   ),
        .cpu_rom_addr ( cpu_rom_addr ),
        .pcm_we       ( pcm_we       )
    );

    snd_rom_arb u_arb(
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .cpu_rom_cs   ( cpu_rom_cs   ),
        .cpu_rom_addr ( cpu_rom_addr ),
        .pcm_rom_cs   ( pcm_rom_cs   ),
        .pcm_rom_addr ( pcm_rom_addr ),
        .rom_data     ( rom_data     ),
        .rom_ok       ( rom_ok       ),
        .cpu_rom_data ( cpu_rom_data ),
        .cpu_rom_ok   ( cpu_rom_ok   ),
        .pcm_rom_data ( pcm_rom_data ),
        .pcm_rom_ok   ( pcm_rom_ok   ),
        .rom_addr     ( rom_addr     ),
        .rom_cs       ( rom_cs       )
    );

    snd_adpcm u_adpcm(
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .cen_oki      ( cen_oki      ),
        .pcm_we       ( pcm_we       ),
        .cpu_dout     ( cpu_dout     ),
        .pcm_rom_data ( pcm_rom_data ),
        .pcm_rom_ok   ( pcm_rom_ok   ),
        .pcm_rom_cs   ( pcm_rom_cs   ),
        .pcm_rom_addr ( pcm_rom_addr ),
        .pcm_status   ( pcm_status   ),
        .pcm_snd      ( pcm_snd      )
    );

    snd_mixer u_mixer(
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .cen_mix      ( cen_mix      ),
        .fm_snd       ( fm_snd       ),   // FM synth lives outside
        .pcm_snd      ( pcm_snd      ),
        .sound        ( sound        ),
        .sample       ( sample       ),
        .peak         ( peak         )
    );

endmodule

`default_nettype wire

/* vlog.f */
design/snd_pkg.sv
design/snd_decode.sv
design/snd_rom_arb.sv
design/snd_adpcm.sv
design/snd_mixer.sv
design/snd_top.sv
bench/snd_tb.sv
